//--- hw/pwm_audio.sv
////////////////////
// PWM audio
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rle_video_defs.svh"

module pwm_audio (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`PWM_BITS-1:0] level,
  output logic                 pwm
);

  logic [`PWM_BITS-1:0] cnt;
  logic [`PWM_BITS-1:0] level_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
      level_q <= '0;
      pwm <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
      if (cnt == '1) begin
        level_q <= level;      // new level only at period start
      end
      pwm <= (cnt < level_q);
    end
  end

endmodule

`default_nettype wire

//--- hw/rle_decoder.sv
////////////////////
// RLE decoder
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rle_video_defs.svh"

module rle_decoder (
  input  logic                    clk,
  input  logic                    rst_n,
  timing_if.dec                   tim,
  input  rle_video_pkg::word_t    data,
  input  logic                    data_ready,
  output logic                    read_next,
  output logic                    stop_read,
  output rle_video_pkg::colour_t  colour,
  output logic                    pixel_valid,
  output logic [`PWM_BITS-1:0]    audio_level
);

  localparam int RB = `RUN_BITS;

  logic                   fetch_en;
  logic [RB-1:0]          run_left;    // pixels left in the current run
  rle_video_pkg::colour_t run_colour;
  logic                   pf_valid;
  rle_video_pkg::word_t   pf_word;
  logic                   pixel;
  logic                   fetch_run;
  logic                   fetch_ctrl;
  logic                   run_done;
  logic                   take_pf;
  logic                   take_data;
  rle_video_pkg::word_t   next_word;
  logic [RB-1:0]          next_len;

  assign pixel = !tim.blank;
  assign read_next = fetch_en && data_ready && !pf_valid && !tim.next_frame;
  assign fetch_run = read_next && !data.run.kind;
  assign fetch_ctrl = read_next && data.ctrl.kind;
  assign stop_read = fetch_ctrl && (data.ctrl.op == rle_video_pkg::op_end_frame);

  // current run is empty or ends with this pixel
  assign run_done = (run_left == '0) || (pixel && run_left == RB'(1));
  assign take_pf = run_done && pf_valid;
  assign take_data = run_done && !pf_valid && fetch_run;   // bypass the prefetch slot
  assign next_word = pf_valid ? pf_word : data;
  assign next_len = (next_word.run.run_len == '0) ? RB'(1) : next_word.run.run_len;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en <= 1'b0;
      run_left <= '0;
      pf_valid <= 1'b0;
      pixel_valid <= 1'b0;
      audio_level <= '0;
    end else begin
      pixel_valid <= pixel && (run_left != '0);   // pixel lost if no run
      if (fetch_ctrl && data.ctrl.op == rle_video_pkg::op_audio) begin
        audio_level <= data.ctrl.arg;
      end
      if (tim.next_frame) begin
        // timing starts a frame right after reset, so the first frame fetches too
        fetch_en <= 1'b1;
        run_left <= '0;
        pf_valid <= 1'b0;
      end else begin
        if (stop_read) begin
          fetch_en <= 1'b0;            // wait for next frame
        end
        if (take_pf || take_data) begin
          run_left <= next_len;
        end else if (pixel && run_left != '0) begin
          run_left <= run_left - 1'b1;
        end
        if (take_pf) begin
          pf_valid <= 1'b0;
        end else if (fetch_run && !take_data) begin
          pf_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_pf || take_data) begin
      run_colour <= next_word.run.colour;
    end
    if (fetch_run) begin
      pf_word <= data;
    end
    if (pixel) begin
      colour <= run_colour;
    end
  end

endmodule

`default_nettype wire

//--- hw/rle_vga_top.sv
////////////////////
// RLE VGA player
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rle_video_defs.svh"

module rle_vga_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] data,
  input  logic        data_ready,
  output logic        read_next,
  output logic        stop_read,
  output logic [7:0]  uo_out,
  output logic        pwm,
  output logic        underrun
);

  timing_if tim ();

  rle_video_pkg::colour_t colour;
  logic                   pixel_valid;
  logic [`PWM_BITS-1:0]   audio_level;

  vga_timing u_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .tim   (tim)
  );

  rle_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .tim         (tim),
    .data        (data),
    .data_ready  (data_ready),
    .read_next   (read_next),
    .stop_read   (stop_read),
    .colour      (colour),
    .pixel_valid (pixel_valid),
    .audio_level (audio_level)
  );

  video_out u_video_out (
    .clk         (clk),
    .rst_n       (rst_n),
    .tim         (tim),
    .colour      (colour),
    .pixel_valid (pixel_valid),
    .uo_out      (uo_out),
    .underrun    (underrun)
  );

  pwm_audio u_pwm (
    .clk   (clk),
    .rst_n (rst_n),
    .level (audio_level),
    .pwm   (pwm)
  );

endmodule

`default_nettype wire

//--- hw/rle_video_defs.svh
////////////////////
// RLE video defines
////////////////////

`ifndef RLE_VIDEO_DEFS_SVH
`define RLE_VIDEO_DEFS_SVH

// horizontal segments in pixel clocks
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3

// vertical segments in lines
`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 1
`define V_BACK 1

`define WORD_BITS 16
`define COLOUR_BITS 6
`define RUN_BITS 9     // run length field, bits 14:6
`define OP_BITS 2      // control opcode, bits 14:13
`define PWM_BITS 8     // audio level, also the control argument in bits 7:0

`endif

//--- hw/rle_video_pkg.sv
////////////////////
// RLE video types
////////////////////

`default_nettype none

`include "rle_video_defs.svh"

package rle_video_pkg;

  // r1 g1 b1 r0 g0 b0
  typedef logic [`COLOUR_BITS-1:0] colour_t;

  typedef enum logic [`OP_BITS-1:0] {
    op_audio     = 2'd0,
    op_end_frame = 2'd1
  } ctrl_op_t;

  typedef struct packed {
    logic                 kind;      // 0 for a pixel run
    logic [`RUN_BITS-1:0] run_len;   // zero reads as one
    colour_t              colour;
  } run_word_t;

  typedef struct packed {
    logic                                      kind;  // 1 for control
    ctrl_op_t                                  op;
    logic [`WORD_BITS-2-`OP_BITS-`PWM_BITS:0]  pad;
    logic [`PWM_BITS-1:0]                      arg;
  } ctrl_word_t;

  typedef union packed {
    run_word_t  run;
    ctrl_word_t ctrl;
  } word_t;

endpackage

`default_nettype wire

//--- hw/timing_if.sv
////////////////////
// Raster timing
////////////////////

`timescale 1ns/10ps
`default_nettype none

interface timing_if;
  logic hsync;       // active low
  logic vsync;       // active low
  logic blank;
  logic next_row;
  logic next_frame;

  modport src (output hsync, vsync, blank, next_row, next_frame);
  modport dec (input blank, next_frame);
  modport out (input hsync, vsync, blank);
endinterface

`default_nettype wire

//--- hw/vga_timing.sv
////////////////////
// VGA timing
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rle_video_defs.svh"

module vga_timing (
  input logic clk,
  input logic rst_n,
  timing_if.src tim
);

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END = HS_START + `H_SYNC;
  // frame starts with vsync so the decoder can refill before active lines
  localparam int VA_START = `V_SYNC + `V_BACK;
  localparam int VA_END = VA_START + `V_ACTIVE;
  localparam int V_TOTAL = VA_END + `V_FRONT;
  localparam int H_W = $clog2(H_TOTAL);
  localparam int V_W = $clog2(V_TOTAL);

  logic [H_W-1:0] h_cnt;
  logic [H_W-1:0] h_next;
  logic [V_W-1:0] v_cnt;
  logic [V_W-1:0] v_next;

  always_comb begin
    h_next = (h_cnt == H_W'(H_TOTAL - 1)) ? '0 : h_cnt + 1'b1;
    v_next = v_cnt;
    if (h_cnt == H_W'(H_TOTAL - 1)) begin
      v_next = (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
    end
  end

  // outputs are decoded from the next count so they line up with the counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= H_W'(H_TOTAL - 1);    // last clock of a frame
      v_cnt <= V_W'(V_TOTAL - 1);
      tim.hsync <= 1'b1;
      tim.vsync <= 1'b1;
      tim.blank <= 1'b1;
      tim.next_row <= 1'b0;
      tim.next_frame <= 1'b0;
    end else begin
      h_cnt <= h_next;
      v_cnt <= v_next;
      tim.hsync <= !(h_next >= HS_START && h_next < HS_END);
      tim.vsync <= !(v_next < `V_SYNC);
      tim.blank <= (h_next >= `H_ACTIVE) || (v_next < VA_START) || (v_next >= VA_END);
      tim.next_row <= (h_next == '0);
      tim.next_frame <= (h_next == '0) && (v_next == '0);
    end
  end

endmodule

`default_nettype wire

//--- hw/video_out.sv
////////////////////
// Video output
////////////////////

`timescale 1ns/10ps
`default_nettype none

module video_out (
  input  logic                   clk,
  input  logic                   rst_n,
  timing_if.out                  tim,
  input  rle_video_pkg::colour_t colour,
  input  logic                   pixel_valid,
  output logic [7:0]             uo_out,
  output logic                   underrun
);

  logic                   hsync_d;
  logic                   vsync_d;
  logic                   blank_d;
  rle_video_pkg::colour_t pix;

  // black when blanking or when the decoder had nothing
  assign pix = (blank_d || !pixel_valid) ? '0 : colour;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync_d <= 1'b1;
      vsync_d <= 1'b1;
      blank_d <= 1'b1;
      uo_out <= 8'h88;     // syncs idle high
      underrun <= 1'b0;
    end else begin
      hsync_d <= tim.hsync;
      vsync_d <= tim.vsync;
      blank_d <= tim.blank;
      uo_out <= {hsync_d, pix[0], pix[2], pix[4], vsync_d, pix[1], pix[3], pix[5]};
      if (!blank_d && !pixel_valid) begin
        underrun <= 1'b1;  // sticky
      end
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/rle_video_pkg.sv
hw/timing_if.sv
hw/vga_timing.sv
hw/rle_decoder.sv
hw/video_out.sv
hw/pwm_audio.sv
hw/rle_vga_top.sv
tests/rle_vga_tb.sv

//--- tests/rle_trace.txt
# columns: stream word in hex, clocks with data_ready low before that word
# the last frame has a long gap for the underrun check
8040 0
043F 2
0205 0
002A 1
01D5 0
0830 0
A000 1
C000 0
050C 0
0321 1
081B 0
A000 0
0217 0
0E09 200
A000 0

//--- tests/rle_vga_tb.sv
////////////////////
// RLE player testbench
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rle_video_defs.svh"

module rle_vga_tb;

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int VA_START = `V_SYNC + `V_BACK;   // vsync opens the frame
  localparam int V_TOTAL = VA_START + `V_ACTIVE + `V_FRONT;
  localparam int FRAME = H_TOTAL * V_TOTAL;
  localparam int PIXELS = `H_ACTIVE * `V_ACTIVE;

  logic        clk;
  logic        rst_n;
  logic [15:0] data;
  logic        data_ready;
  logic        read_next;
  logic        stop_read;
  logic [7:0]  uo_out;
  logic        pwm;
  logic        underrun;

  logic [15:0] words[$];
  int          gaps[$];
  logic [5:0]  exp_pix[0:7][0:PIXELS-1];
  logic        exp_ok[0:7][0:PIXELS-1];   // pixel has an on-time run
  int          nframes;
  int          audio_lvl;
  int          cyc;

  rle_vga_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .data       (data),
    .data_ready (data_ready),
    .read_next  (read_next),
    .stop_read  (stop_read),
    .uo_out     (uo_out),
    .pwm        (pwm),
    .underrun   (underrun)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n) cyc <= cyc + 1;   // rising edges since reset release
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, expected);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("%s at %0t", why, $time);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic load_trace();
    int fd;
    int g;
    int f;
    int pix;
    int len;
    logic [15:0] w;
    string line;
    logic late;
    fd = $fopen("tests/rle_trace.txt", "r");
    if (fd == 0) stop_with_error("cannot open tests/rle_trace.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%h %d", w, g) == 2) begin
        words.push_back(w);
        gaps.push_back(g);
      end
    end
    $fclose(fd);
    f = 0;
    pix = 0;
    late = 1'b0;
    audio_lvl = 0;
    for (int a = 0; a < 8; a++) begin
      for (int b = 0; b < PIXELS; b++) begin
        exp_pix[a][b] = '0;
        exp_ok[a][b] = 1'b0;
      end
    end
    foreach (words[i]) begin
      w = words[i];
      if (gaps[i] >= FRAME) late = 1'b1;   // arrives after the active lines
      if (!w[15]) begin
        len = (w[14:6] == 0) ? 1 : w[14:6];
        repeat (len) begin
          if (pix < PIXELS && !late) begin
            exp_pix[f][pix] = w[5:0];
            exp_ok[f][pix] = 1'b1;
          end
          pix++;
        end
      end else if (w[14:13] == 2'd0) begin
        audio_lvl = w[7:0];
      end else if (w[14:13] == 2'd1) begin
        f++;
        pix = 0;
        late = 1'b0;
      end
    end
    nframes = f;
  endtask

  task automatic serve_words();
    int t;
    int last_end;
    logic after_end;
    after_end = 1'b0;
    last_end = 0;
    foreach (words[i]) begin
      data_ready = 1'b0;
      repeat (gaps[i]) @(negedge clk);
      data = words[i];
      data_ready = 1'b1;
      #10;
      t = 0;
      while (!read_next) begin
        t++;
        if (t > 400) stop_with_error($sformatf("read_next never came for word %0d", i));
        @(negedge clk);
        #10;
      end
      check_value("stop_read", stop_read, words[i][15:13] == 3'b101);
      // cyc - 1 is the raster position of this cycle
      if (after_end && (cyc - 1) / FRAME <= (last_end - 1) / FRAME)
        stop_with_error("read_next came before the next frame started");
      after_end = (words[i][15:13] == 3'b101);
      last_end = cyc;
      @(negedge clk);
    end
    data_ready = 1'b0;
  endtask

  task automatic check_pins();
    int p;
    int h;
    int ln;
    int f;
    int idx;
    logic [5:0] got_c;
    logic exp_under;
    exp_under = 1'b0;
    for (int j = 1; j < nframes * FRAME + 3; j++) begin
      @(negedge clk);
      p = j - 3;   // raster position shown on the pins
      if (p < 0) begin
        check_value("uo_out", uo_out, 8'h88);
        continue;
      end
      h = p % H_TOTAL;
      ln = (p / H_TOTAL) % V_TOTAL;
      f = p / FRAME;
      got_c = {uo_out[0], uo_out[4], uo_out[1], uo_out[5], uo_out[2], uo_out[6]};
      check_value("hsync", uo_out[7], !(h >= HS_START && h < HS_START + `H_SYNC));
      check_value("vsync", uo_out[3], ln >= `V_SYNC);
      if (h >= `H_ACTIVE || ln < VA_START || ln >= VA_START + `V_ACTIVE) begin
        check_value("blanked colour", got_c, 0);
      end else begin
        idx = (ln - VA_START) * `H_ACTIVE + h;
        if (!exp_ok[f][idx]) exp_under = 1'b1;
        check_value($sformatf("pixel %0d of frame %0d", idx, f), got_c, exp_pix[f][idx]);
      end
      check_value("underrun", underrun, exp_under);
    end
  endtask

  task automatic measure_pwm();
    int t;
    int hi;
    logic prev;
    prev = 1'b1;
    t = 0;
    @(negedge clk);
    while (prev || !pwm) begin
      prev = pwm;
      t++;
      if (t > 700) stop_with_error("pwm never rose");
      @(negedge clk);
    end
    for (int n = 0; n < 2; n++) begin
      hi = 0;
      repeat (256) begin
        if (pwm) hi++;
        @(negedge clk);
      end
      check_value("pwm high clocks", hi, audio_lvl);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    data = '0;
    data_ready = 1'b0;
    cyc = 0;
    load_trace();
    repeat (16) @(negedge clk);
    check_value("read_next", read_next, 0);
    check_value("stop_read", stop_read, 0);
    check_value("pwm", pwm, 0);
    check_value("underrun", underrun, 0);
    check_value("uo_out", uo_out, 8'h88);
    rst_n = 1'b1;
    fork
      serve_words();
      check_pins();
      measure_pwm();
    join
    check_value("underrun", underrun, 1);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
